/* source/simt_pkg.sv */
// Widths, opcodes, the instruction word and the stage types of the warp front end
// Imported by every block of the front end and by the testbench
package simt_pkg;

    // ########################################
    // Sizes
    // ########################################

    // Threads in one warp
    localparam int unsigned warp_width = 8;
    localparam int unsigned pc_width = 8;
    // One program word per PC value
    localparam int unsigned prog_depth = 256;
    // Deepest nesting the programs may reach
    localparam int unsigned stack_depth = 8;
    localparam int unsigned stack_ptr_width = $clog2(stack_depth);
    localparam int unsigned lane_id_width = $clog2(warp_width);

    typedef logic [pc_width-1:0] pc_t;
    typedef logic [warp_width-1:0] act_mask_t;
    typedef logic [lane_id_width-1:0] lane_id_t;
    typedef logic [stack_ptr_width-1:0] stack_ptr_t;

    // ########################################
    // Instruction encoding
    // ########################################

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_BRA  = 4'h1,
        OP_HALT = 4'hf
    } opcode_e;

    // Per-lane branch conditions
    typedef enum logic [1:0] {
        COND_LANE_LT  = 2'd0,  // lane number below threshold
        COND_LANE_BIT = 2'd1,  // bit sel of lane number set
        COND_ALWAYS   = 2'd2,
        COND_NEVER    = 2'd3
    } cond_e;

    // Plain view, tag only labels the trace
    typedef struct packed {
        opcode_e     opcode;
        logic [19:0] unused;
        logic [7:0]  tag;
    } plain_instr_t;

    // Branch view, same opcode field position
    typedef struct packed {
        opcode_e    opcode;
        cond_e      cond;
        lane_id_t   threshold;
        logic [1:0] sel;
        logic [4:0] spare;
        pc_t        target_pc;
        pc_t        reconv_pc;
    } branch_instr_t;

    typedef union packed {
        plain_instr_t  plain;
        branch_instr_t branch;
    } instr_u;

    // ########################################
    // Stage results
    // ########################################

    // Decoder to stack
    typedef struct packed {
        logic is_branch;
        logic is_halt;
        pc_t  pc;
        // PC+1 for plain words, reconvergence PC for branches
        pc_t  next_or_reconv_pc;
    } decode_t;

    // Branch unit to stack
    typedef struct packed {
        act_mask_t branching_mask;
        pc_t       taken_pc;
        pc_t       inactive_pc;
    } bru_result_t;

    // Issue trace entry
    typedef struct packed {
        pc_t       pc;
        act_mask_t act_mask;
        instr_u    instr;
    } issue_t;

endpackage

/* source/fetch_unit.sv */
`timescale 1ns/1ps
// Program memory and run control of the warp front end
// Selects the stack for fetch when ready and returns the word one cycle later
module fetch_unit import simt_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      start_i,
    // Program load port
    input  logic      prog_we_i,
    input  pc_t       prog_addr_i,
    input  instr_u    prog_wdata_i,
    // Stack handshake
    input  logic      ready_for_fetch_i,
    input  pc_t       fetch_pc_i,
    input  act_mask_t fetch_mask_i,
    input  logic      halt_seen_i,
    output logic      fetch_select_o,
    // Fetched word to decoder
    output logic      word_valid_o,
    output instr_u    word_o,
    output pc_t       word_pc_o,
    output act_mask_t word_mask_o,
    output logic      done_o
);
    instr_u    prog_mem [prog_depth];
    logic      running_q;
    logic      halted_q;
    logic      word_valid_q;
    instr_u    word_q;
    pc_t       word_pc_q;
    act_mask_t word_mask_q;

    // Select drops on its own once the stack clears ready
    // A halted unit is never running
    assign fetch_select_o = ready_for_fetch_i && running_q;

    // Start wins over a late halt
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            running_q    <= 1'b0;
            halted_q     <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= fetch_select_o;
            if (start_i) begin
                running_q <= 1'b1;
                halted_q  <= 1'b0;
            end else if (halt_seen_i) begin
                running_q <= 1'b0;
                halted_q  <= 1'b1;
            end
        end
    end

    // Write port and synchronous read
    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            prog_mem[prog_addr_i] <= prog_wdata_i;
        end
        if (fetch_select_o) begin
            word_q      <= prog_mem[fetch_pc_i];
            word_pc_q   <= fetch_pc_i;
            word_mask_q <= fetch_mask_i;
        end
    end

    assign word_valid_o = word_valid_q;
    assign word_o       = word_q;
    assign word_pc_o    = word_pc_q;
    assign word_mask_o  = word_mask_q;
    assign done_o       = halted_q;

endmodule

/* source/warp_decoder.sv */
`timescale 1ns/1ps
// Decode stage of the warp front end
// Registers the fetched word, decodes it and forwards branches to the branch unit
module warp_decoder import simt_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    // From fetch
    input  logic      word_valid_i,
    input  instr_u    word_i,
    input  pc_t       word_pc_i,
    input  act_mask_t word_mask_i,
    // To stack
    output logic      decoded_valid_o,
    output decode_t   decode_o,
    // Issue trace
    output logic      issue_valid_o,
    output issue_t    issue_o,
    // To branch unit
    output logic      br_valid_o,
    output instr_u    br_word_o,
    output act_mask_t br_mask_o
);
    logic      valid_q;
    instr_u    word_q;
    pc_t       pc_q;
    act_mask_t mask_q;
    logic      is_branch;
    logic      is_halt;

    // ########################################
    // Word register
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_valid_i;
        end
    end

    // Word, PC and mask of the fetched instruction
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            word_q <= word_i;
            pc_q   <= word_pc_i;
            mask_q <= word_mask_i;
        end
    end

    // ########################################
    // Decode
    // ########################################

    // Opcode read through the plain view
    assign is_branch = (word_q.plain.opcode == OP_BRA);
    assign is_halt   = (word_q.plain.opcode == OP_HALT);

    always_comb begin
        // Flags hold only while the word is valid
        decode_o.is_branch = valid_q && is_branch;
        decode_o.is_halt   = valid_q && is_halt;
        decode_o.pc        = pc_q;
        // Branch view gives reconvergence point
        if (is_branch) begin
            decode_o.next_or_reconv_pc = word_q.branch.reconv_pc;
        end else begin
            decode_o.next_or_reconv_pc = pc_q + pc_t'(1);
        end
    end

    assign decoded_valid_o = valid_q;

    // One trace event per decoded word
    assign issue_valid_o     = valid_q;
    assign issue_o.pc        = pc_q;
    assign issue_o.act_mask  = mask_q;
    assign issue_o.instr     = word_q;

    // Branch words go on to the branch unit
    assign br_valid_o = valid_q && is_branch;
    assign br_word_o  = word_q;
    assign br_mask_o  = mask_q;

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps
// Per-lane branch evaluation of the warp front end
// Produces the taken mask and both successor PCs one cycle after the branch
module branch_unit import simt_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    // From decoder
    input  logic        br_valid_i,
    input  instr_u      br_word_i,
    input  act_mask_t   br_mask_i,
    input  pc_t         br_pc_i,
    // To stack
    output logic        bru_valid_o,
    output bru_result_t bru_o
);
    act_mask_t   lane_cond;
    act_mask_t   branching_mask;
    logic        valid_q;
    bru_result_t result_q;

    // ########################################
    // Lane conditions
    // ########################################

    // Condition per lane, taken from the lane number alone
    always_comb begin
        lane_id_t lane;
        lane = '0;
        for (int i = 0; i < warp_width; i++) begin
            lane = lane_id_t'(i);
            case (br_word_i.branch.cond)
                COND_LANE_LT: begin
                    lane_cond[i] = (lane < br_word_i.branch.threshold);
                end
                COND_LANE_BIT: begin
                    // sel beyond the lane width tests nothing
                    lane_cond[i] = |(lane & (lane_id_t'(1) << br_word_i.branch.sel));
                end
                COND_ALWAYS: begin
                    lane_cond[i] = 1'b1;
                end
                default: begin
                    lane_cond[i] = 1'b0;
                end
            endcase
        end
    end

    // Inactive lanes never take the branch
    assign branching_mask = lane_cond & br_mask_i;

    // ########################################
    // Result register
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= br_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (br_valid_i) begin
            result_q.branching_mask <= branching_mask;
            result_q.taken_pc       <= br_word_i.branch.target_pc;
            // Fall through to the next word
            result_q.inactive_pc    <= br_pc_i + pc_t'(1);
        end
    end

    assign bru_valid_o = valid_q;
    assign bru_o       = result_q;

endmodule

/* source/reconvergence_stack.sv */
`timescale 1ns/1ps
// Reconvergence stack of one warp
// Tracks divergent paths and hands the top entry's PC and mask to fetch
module reconvergence_stack import simt_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    // Start of a run
    input  logic        init_i,
    // Fetch handshake
    input  logic        fetch_select_i,
    output logic        ready_for_fetch_o,
    output pc_t         fetch_pc_o,
    output act_mask_t   fetch_mask_o,
    // From decoder
    input  logic        decoded_valid_i,
    input  decode_t     decode_i,
    // From branch unit
    input  logic        bru_valid_i,
    input  bru_result_t bru_i
);
    // One path of execution
    typedef struct packed {
        pc_t       pc;
        act_mask_t act_mask;
        // Pop point of this path
        pc_t       reconv_pc;
    } stack_entry_t;

    stack_entry_t stack_q [stack_depth];
    stack_entry_t stack_d [stack_depth];
    stack_ptr_t   ptr_q;
    stack_ptr_t   ptr_d;
    stack_ptr_t   ptr_plus1;
    stack_ptr_t   ptr_plus2;
    logic         ready_q;
    logic         ready_d;
    pc_t          reconv_pc_q;
    pc_t          reconv_pc_d;
    stack_entry_t top;
    logic         at_reconv;
    act_mask_t    not_taken_mask;

    // ########################################
    // Top entry helpers
    // ########################################

    assign top       = stack_q[ptr_q];
    assign ptr_plus1 = ptr_q + stack_ptr_t'(1);
    assign ptr_plus2 = ptr_q + stack_ptr_t'(2);

    // Bottom entry never pops
    assign at_reconv = (ptr_q != '0) && (decode_i.next_or_reconv_pc == top.reconv_pc);

    // Active lanes that fall through
    assign not_taken_mask = top.act_mask & ~bru_i.branching_mask;

    // ########################################
    // Next state
    // ########################################

    always_comb begin
        stack_d     = stack_q;
        ptr_d       = ptr_q;
        ready_d     = ready_q;
        reconv_pc_d = reconv_pc_q;

        if (init_i) begin
            // All lanes start at PC 0
            ptr_d                = '0;
            stack_d[0].pc        = '0;
            stack_d[0].act_mask  = '1;
            stack_d[0].reconv_pc = '0;
            ready_d              = 1'b1;
        end else begin
            if (fetch_select_i) begin
                ready_d = 1'b0;
            end

            if (decoded_valid_i) begin
                if (decode_i.is_branch) begin
                    // Hold R until the branch unit answers
                    reconv_pc_d = decode_i.next_or_reconv_pc;
                end else begin
                    if (at_reconv) begin
                        ptr_d = ptr_q - stack_ptr_t'(1);
                    end else begin
                        stack_d[ptr_q].pc = decode_i.next_or_reconv_pc;
                    end
                    // HALT also lands here and fetch ignores its ready
                    ready_d = 1'b1;
                end
            end

            if (bru_valid_i) begin
                if (bru_i.branching_mask == '0) begin
                    // No lane taken
                    stack_d[ptr_q].pc = bru_i.inactive_pc;
                end else if (bru_i.branching_mask == top.act_mask) begin
                    // Every active lane taken
                    stack_d[ptr_q].pc = bru_i.taken_pc;
                end else begin
                    // Parent entry waits at R
                    stack_d[ptr_q].pc = reconv_pc_q;
                    // Not-taken path runs second
                    stack_d[ptr_plus1].pc        = bru_i.inactive_pc;
                    stack_d[ptr_plus1].act_mask  = not_taken_mask;
                    stack_d[ptr_plus1].reconv_pc = reconv_pc_q;
                    // Taken path on top runs first
                    stack_d[ptr_plus2].pc        = bru_i.taken_pc;
                    stack_d[ptr_plus2].act_mask  = bru_i.branching_mask;
                    stack_d[ptr_plus2].reconv_pc = reconv_pc_q;
                    ptr_d = ptr_plus2;
                end
                ready_d = 1'b1;
            end
        end
    end

    // ########################################
    // Registers
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_q <= 1'b0;
            ptr_q   <= '0;
        end else begin
            ready_q <= ready_d;
            ptr_q   <= ptr_d;
        end
    end

    // Entry storage and the held reconvergence PC
    always_ff @(posedge clk_i) begin
        stack_q     <= stack_d;
        reconv_pc_q <= reconv_pc_d;
    end

    assign ready_for_fetch_o = ready_q;
    assign fetch_pc_o        = top.pc;
    assign fetch_mask_o      = top.act_mask;

endmodule

/* source/simt_warp_frontend.sv */
`timescale 1ns/1ps
// Top level of the warp front end
// Wires fetch, decode, branch unit and reconvergence stack together
module simt_warp_frontend import simt_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   start_i,
    // Program load port
    input  logic   prog_we_i,
    input  pc_t    prog_addr_i,
    input  instr_u prog_wdata_i,
    // Issue trace
    output logic   issue_valid_o,
    output issue_t issue_o,
    output logic   done_o
);
    // Fetch handshake
    logic        ready_for_fetch;
    logic        fetch_select;
    pc_t         fetch_pc;
    act_mask_t   fetch_mask;
    // Fetched word
    logic        word_valid;
    instr_u      word;
    pc_t         word_pc;
    act_mask_t   word_mask;
    // Decode and branch results
    logic        decoded_valid;
    decode_t     decode;
    logic        br_valid;
    instr_u      br_word;
    act_mask_t   br_mask;
    logic        bru_valid;
    bru_result_t bru;

    fetch_unit fetch_unit_inst (
        .clk_i, .rst_i, .start_i,
        .prog_we_i, .prog_addr_i, .prog_wdata_i,
        .ready_for_fetch_i (ready_for_fetch), .fetch_pc_i (fetch_pc),
        .fetch_mask_i (fetch_mask), .halt_seen_i (decode.is_halt),
        .fetch_select_o (fetch_select), .word_valid_o (word_valid),
        .word_o (word), .word_pc_o (word_pc), .word_mask_o (word_mask), .done_o
    );

    warp_decoder warp_decoder_inst (
        .clk_i, .rst_i,
        .word_valid_i (word_valid), .word_i (word),
        .word_pc_i (word_pc), .word_mask_i (word_mask),
        .decoded_valid_o (decoded_valid), .decode_o (decode),
        .issue_valid_o, .issue_o,
        .br_valid_o (br_valid), .br_word_o (br_word), .br_mask_o (br_mask)
    );

    // Branch PC comes from the decoded word
    branch_unit branch_unit_inst (
        .clk_i, .rst_i,
        .br_valid_i (br_valid), .br_word_i (br_word), .br_mask_i (br_mask),
        .br_pc_i (decode.pc), .bru_valid_o (bru_valid), .bru_o (bru)
    );

    reconvergence_stack reconvergence_stack_inst (
        .clk_i, .rst_i, .init_i (start_i),
        .fetch_select_i (fetch_select), .ready_for_fetch_o (ready_for_fetch),
        .fetch_pc_o (fetch_pc), .fetch_mask_o (fetch_mask),
        .decoded_valid_i (decoded_valid), .decode_i (decode),
        .bru_valid_i (bru_valid), .bru_i (bru)
    );

endmodule

/* tests/tb_simt_warp_frontend.sv */
`timescale 1ns/1ps
// Directed testbench for the warp front end
// Loads small programs, runs them and checks the issue trace against a stack model
module tb_simt_warp_frontend import simt_pkg::*; ();
    logic   clk_i;
    logic   rst_i;
    logic   start_i;
    logic   prog_we_i;
    pc_t    prog_addr_i;
    instr_u prog_wdata_i;
    logic   issue_valid_o;
    issue_t issue_o;
    logic   done_o;

    // Program image that load_program copies into the DUT
    instr_u      prog [prog_depth];
    issue_t      expected_q [$];
    logic [31:0] rng_state;

    simt_warp_frontend simt_warp_frontend_inst (.*);

    // 20 ns period
    always #10 clk_i = ~clk_i;

    // ########################################
    // Checks
    // ########################################

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_issue(input issue_t got, input issue_t exp);
        if (got !== exp) begin
            $display("ERR %0t issue got pc %02h mask %02h word %08h", $time,
                     got.pc, got.act_mask, got.instr);
            $display("ERR %0t issue expected pc %02h mask %02h word %08h", $time,
                     exp.pc, exp.act_mask, exp.instr);
            abort_run();
        end
    endtask

    task automatic compare_done(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t done_o is %b during %s, expected %b", $time, got, what, exp);
            abort_run();
        end
    endtask

    // ########################################
    // Instruction words
    // ########################################

    function automatic instr_u nop_word(input logic [7:0] tag);
        instr_u w;
        w = '0;
        w.plain.opcode = OP_NOP;
        w.plain.tag    = tag;
        return w;
    endfunction

    function automatic instr_u halt_word();
        instr_u w;
        w = '0;
        w.plain.opcode = OP_HALT;
        return w;
    endfunction

    function automatic instr_u bra_word(input cond_e c, input lane_id_t thr,
                                        input logic [1:0] sel, input pc_t target,
                                        input pc_t reconv);
        instr_u w;
        w = '0;
        w.branch.opcode    = OP_BRA;
        w.branch.cond      = c;
        w.branch.threshold = thr;
        w.branch.sel       = sel;
        w.branch.target_pc = target;
        w.branch.reconv_pc = reconv;
        return w;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ########################################
    // Reference model
    // ########################################

    // Taken lanes before masking with the active lanes
    function automatic act_mask_t lane_rule(input instr_u w);
        act_mask_t m;
        for (int lane = 0; lane < warp_width; lane++) begin
            case (w.branch.cond)
                COND_LANE_LT:  m[lane] = (lane < int'(w.branch.threshold));
                COND_LANE_BIT: m[lane] = (((lane >> w.branch.sel) & 1) == 1);
                COND_ALWAYS:   m[lane] = 1'b1;
                default:       m[lane] = 1'b0;
            endcase
        end
        return m;
    endfunction

    // Walks the program with its own stack and queues every issue event
    task automatic build_expected();
        pc_t       m_pc [stack_depth];
        act_mask_t m_mask [stack_depth];
        pc_t       m_reconv [stack_depth];
        int        sp;
        int        steps;
        logic      halted;
        instr_u    w;
        act_mask_t taken;
        issue_t    ev;
        expected_q.delete();
        sp          = 0;
        steps       = 0;
        halted      = 1'b0;
        m_pc[0]     = '0;
        m_mask[0]   = '1;
        m_reconv[0] = '0;
        while (!halted) begin
            if (steps > 500) begin
                $display("Reference model did not reach a HALT within 500 steps");
                abort_run();
            end
            w           = prog[m_pc[sp]];
            ev.pc       = m_pc[sp];
            ev.act_mask = m_mask[sp];
            ev.instr    = w;
            expected_q.push_back(ev);
            steps++;
            if (w.plain.opcode == OP_HALT) begin
                halted = 1'b1;
            end else if (w.plain.opcode == OP_BRA) begin
                taken = lane_rule(w) & m_mask[sp];
                if (taken == '0) begin
                    m_pc[sp] = m_pc[sp] + pc_t'(1);
                end else if (taken == m_mask[sp]) begin
                    m_pc[sp] = w.branch.target_pc;
                end else begin
                    if (sp + 2 >= stack_depth) begin
                        $display("Reference model nested deeper than the stack");
                        abort_run();
                    end
                    // Fall-through lanes below, taken lanes on top
                    m_pc[sp + 1]     = m_pc[sp] + pc_t'(1);
                    m_mask[sp + 1]   = m_mask[sp] & ~taken;
                    m_reconv[sp + 1] = w.branch.reconv_pc;
                    m_pc[sp + 2]     = w.branch.target_pc;
                    m_mask[sp + 2]   = taken;
                    m_reconv[sp + 2] = w.branch.reconv_pc;
                    m_pc[sp]         = w.branch.reconv_pc;
                    sp               = sp + 2;
                end
            end else if (sp > 0 && (m_pc[sp] + pc_t'(1)) == m_reconv[sp]) begin
                sp--;
            end else begin
                m_pc[sp] = m_pc[sp] + pc_t'(1);
            end
        end
    endtask

    // ########################################
    // Program load and run
    // ########################################

    // Unused words are NOPs tagged with their own address
    task automatic clear_program();
        for (int a = 0; a < prog_depth; a++) begin
            prog[a] = nop_word(8'(a));
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < prog_depth; a++) begin
            @(posedge clk_i);
            #2;
            prog_we_i    = 1'b1;
            prog_addr_i  = pc_t'(a);
            prog_wdata_i = prog[a];
        end
        @(posedge clk_i);
        #2;
        prog_we_i = 1'b0;
    endtask

    task automatic check_idle(input int cycles, input logic done_exp);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            if (issue_valid_o !== 1'b0) begin
                $display("ERR %0t issue event at pc %02h while idle", $time, issue_o.pc);
                abort_run();
            end
            compare_done(done_o, done_exp, "idle");
        end
    endtask

    task automatic run_program(input string name);
        issue_t exp;
        int     idle;
        logic   finished;
        build_expected();
        @(posedge clk_i);
        #2;
        start_i = 1'b1;
        @(posedge clk_i);
        #2;
        start_i  = 1'b0;
        idle     = 0;
        finished = 1'b0;
        // Issue events are sampled at the falling edge
        while (!finished) begin
            @(negedge clk_i);
            if (issue_valid_o === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("ERR %0t %s issued pc %02h past the expected trace", $time,
                             name, issue_o.pc);
                    abort_run();
                end
                exp = expected_q.pop_front();
                compare_issue(issue_o, exp);
                idle = 0;
            end else begin
                idle++;
            end
            if (done_o === 1'b1) begin
                finished = 1'b1;
            end else if (idle > 50) begin
                $display("Timeout in %s, no issue event or done for 50 cycles", name);
                abort_run();
            end
        end
        if (expected_q.size() != 0) begin
            $display("Run %s ended with %0d issue events missing", name, expected_q.size());
            abort_run();
        end
        // Done holds and nothing else issues
        check_idle(4, 1'b1);
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic test_straight_line();
        check_idle(10, 1'b0);
        clear_program();
        prog[6] = halt_word();
        load_program();
        check_idle(2, 1'b0);
        run_program("straight line");
    endtask

    task automatic test_uniform_branch();
        clear_program();
        // 2 to 4 are skipped by the jump
        prog[1] = bra_word(COND_ALWAYS, 3'd0, 2'd0, 8'h05, 8'h07);
        prog[6] = bra_word(COND_NEVER, 3'd0, 2'd0, 8'h0a, 8'h08);
        prog[8] = halt_word();
        load_program();
        run_program("uniform branch");
    endtask

    task automatic test_divergent_branch();
        clear_program();
        prog[1] = bra_word(COND_LANE_LT, 3'd3, 2'd0, 8'h04, 8'h06);
        prog[7] = halt_word();
        load_program();
        run_program("divergent branch");
    endtask

    task automatic test_nested_divergence();
        clear_program();
        // Outer split, then odd lanes split again inside
        prog[0]  = bra_word(COND_LANE_LT, 3'd4, 2'd0, 8'h03, 8'h0a);
        prog[3]  = bra_word(COND_LANE_BIT, 3'd0, 2'd0, 8'h06, 8'h08);
        prog[11] = halt_word();
        load_program();
        run_program("nested divergence");
    endtask

    task automatic test_random_thresholds();
        lane_id_t thr;
        rng_state = 32'd33;
        for (int i = 0; i < 10; i++) begin
            rng_state = xorshift32(rng_state);
            thr       = rng_state[2:0];
            clear_program();
            prog[0] = bra_word(COND_LANE_LT, thr, 2'd0, 8'h03, 8'h05);
            prog[5] = halt_word();
            load_program();
            run_program($sformatf("random threshold %0d", thr));
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        start_i      = 1'b0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_wdata_i = '0;
        rng_state    = 32'd33;
        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        test_straight_line();
        test_uniform_branch();
        test_divergent_branch();
        test_nested_divergence();
        test_random_thresholds();
        $display("Test OK");
        $finish;
    end

endmodule

/* project.f */
source/simt_pkg.sv
source/fetch_unit.sv
source/warp_decoder.sv
source/branch_unit.sv
source/reconvergence_stack.sv
source/simt_warp_frontend.sv
tests/tb_simt_warp_frontend.sv

/* Makefile */
# Verilator build for the warp front end testbench
VERILATOR  ?= verilator
TOP        := tb_simt_warp_frontend
RTL_TOP    := simt_warp_frontend
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level and the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# A failing check ends in $$fatal, so the run returns a non-zero status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
